// ==== logic/rv_core_params.svh ====
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// Data path width
`define XLEN 32

// Program counter width, wider than the data path
`define PC_W 64

// Data memory depth in 32-bit words, addressed by alu_result[8:2]
`define DMEM_WORDS 128

// First fetch address
`define RESET_PC 64'd0

`endif

// ==== logic/rv_core_pkg.sv ====
`default_nettype none

package rv_core_pkg;

	// Base opcodes handled by the core, anything else is a no-op
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011, // Register-register arithmetic
		OPC_OP_IMM = 7'b0010011, // Register-immediate arithmetic
		OPC_LOAD   = 7'b0000011, // lw
		OPC_STORE  = 7'b0100011, // sw
		OPC_BRANCH = 7'b1100011  // beq, bne
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SLT  = 4'd5, // Signed compare
		ALU_SLTU = 4'd6, // Unsigned compare
		ALU_SLL  = 4'd7,
		ALU_SRL  = 4'd8,
		ALU_SRA  = 4'd9
	} alu_op_e;

	// Source of the register write-back value
	typedef enum logic {
		WB_ALU = 1'b0,
		WB_MEM = 1'b1
	} wb_sel_e;

endpackage

`default_nettype wire

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module rv_decode
	import rv_core_pkg::*;
(
	input  logic [`XLEN-1:0] inst,
	output logic [4:0]       rs1_addr,
	output logic [4:0]       rs2_addr,
	output logic [4:0]       rd_addr,
	output logic [`XLEN-1:0] imm,
	output alu_op_e          alu_op,
	output logic             alu_src,
	output logic             reg_write,
	output logic             mem_write,
	output logic             is_branch,
	output logic             branch_ne,
	output wb_sel_e          wb_sel
);

	opcode_e          opcode;
	logic [2:0]       funct3;
	logic             funct7_alt; // inst[30], selects sub and sra
	logic [`XLEN-1:0] imm_i;
	logic [`XLEN-1:0] imm_s;
	logic [`XLEN-1:0] imm_b;

	// Maps funct3 of the arithmetic groups onto an ALU operation
	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		case (f3)
			3'b000: arith_op = (is_reg && alt) ? ALU_SUB : ALU_ADD; // No subi
			3'b001: arith_op = ALU_SLL;
			3'b010: arith_op = ALU_SLT;
			3'b011: arith_op = ALU_SLTU;
			3'b100: arith_op = ALU_XOR;
			3'b101: arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110: arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	assign opcode     = opcode_e'(inst[6:0]);
	assign funct3     = inst[14:12];
	assign funct7_alt = inst[30];
	assign rd_addr    = inst[11:7];
	assign rs1_addr   = inst[19:15];
	assign rs2_addr   = inst[24:20];

	// Sign-extended immediates per format
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

	always_comb begin
		imm       = imm_i;
		alu_op    = ALU_ADD;
		alu_src   = 1'b0;
		reg_write = 1'b0; // Unknown opcodes fall through as no-ops
		mem_write = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		wb_sel    = WB_ALU;
		case (opcode)
			OPC_OP: begin
				reg_write = 1'b1;
				alu_op    = arith_op(funct3, funct7_alt, 1'b1);
			end
			OPC_OP_IMM: begin
				reg_write = 1'b1;
				alu_src   = 1'b1;
				alu_op    = arith_op(funct3, funct7_alt, 1'b0);
			end
			OPC_LOAD: begin
				reg_write = 1'b1;
				alu_src   = 1'b1; // Address is rs1 + imm
				wb_sel    = WB_MEM;
			end
			OPC_STORE: begin
				mem_write = 1'b1;
				alu_src   = 1'b1;
				imm       = imm_s;
			end
			OPC_BRANCH: begin
				// Compare by subtraction, execute tests the zero result
				imm       = imm_b;
				alu_op    = ALU_SUB;
				is_branch = (funct3[2:1] == 2'b00); // beq and bne only
				branch_ne = funct3[0];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module rv_regfile (
	input  logic             clk,
	input  logic             rst,
	input  logic [4:0]       rs1_addr,
	input  logic [4:0]       rs2_addr,
	input  logic [4:0]       rd_addr,
	input  logic             reg_write,
	input  logic [`XLEN-1:0] wb_data,
	output logic [`XLEN-1:0] rs1_data,
	output logic [`XLEN-1:0] rs2_data
);

	logic [`XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0; // All registers read zero after reset
			end
		end else if (reg_write && (rd_addr != 5'd0)) begin
			regs[rd_addr] <= wb_data; // x0 stays untouched
		end
	end

	// Combinational reads with x0 hardwired
	assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
	assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module rv_execute
	import rv_core_pkg::*;
(
	input  logic [`XLEN-1:0] rs1_data,
	input  logic [`XLEN-1:0] rs2_data,
	input  logic [`XLEN-1:0] imm,
	input  logic [`PC_W-1:0] pc,
	input  alu_op_e          alu_op,
	input  logic             alu_src,
	input  logic             is_branch,
	input  logic             branch_ne,
	output logic [`XLEN-1:0] alu_result,
	output logic             take_branch,
	output logic [`PC_W-1:0] branch_target
);

	logic [`XLEN-1:0] op_b;
	logic [4:0]       shamt;
	logic             result_zero;

	assign op_b  = alu_src ? imm : rs2_data; // Immediate or rs2
	assign shamt = op_b[4:0];

	always_comb begin
		case (alu_op)
			ALU_ADD:  alu_result = rs1_data + op_b;
			ALU_SUB:  alu_result = rs1_data - op_b;
			ALU_AND:  alu_result = rs1_data & op_b;
			ALU_OR:   alu_result = rs1_data | op_b;
			ALU_XOR:  alu_result = rs1_data ^ op_b;
			ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
			ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, rs1_data < op_b};
			ALU_SLL:  alu_result = rs1_data << shamt;
			ALU_SRL:  alu_result = rs1_data >> shamt;
			ALU_SRA:  alu_result = $unsigned($signed(rs1_data) >>> shamt);
			default:  alu_result = rs1_data + op_b;
		endcase
	end

	// beq takes on a zero difference, bne on a non-zero one
	assign result_zero = (alu_result == '0);
	assign take_branch = is_branch && (branch_ne ? !result_zero : result_zero);

	// Offset is sign-extended to the wider pc
	assign branch_target = pc + {{(`PC_W-`XLEN){imm[`XLEN-1]}}, imm};

endmodule

`default_nettype wire

// ==== logic/rv_result.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module rv_result
	import rv_core_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [`XLEN-1:0] alu_result,
	input  logic [`XLEN-1:0] store_data,
	input  logic             mem_write,
	input  wb_sel_e          wb_sel,
	input  logic             take_branch,
	input  logic [`PC_W-1:0] branch_target,
	output logic [`XLEN-1:0] wb_data,
	output logic [`PC_W-1:0] pc
);

	localparam int AW = $clog2(`DMEM_WORDS);

	logic [`XLEN-1:0] dmem [`DMEM_WORDS];
	logic [AW-1:0]    word_addr;

	// Byte address bits above the word offset, higher bits wrap
	assign word_addr = alu_result[AW+1:2];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				dmem[i] <= '0; // Memory starts cleared
			end
		end else if (mem_write) begin
			dmem[word_addr] <= store_data;
		end
	end

	// Asynchronous read feeds write-back in the same cycle
	assign wb_data = (wb_sel == WB_MEM) ? dmem[word_addr] : alu_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= `RESET_PC;
		end else if (take_branch) begin
			pc <= branch_target;
		end else begin
			pc <= pc + `PC_W'(4); // Sequential fetch
		end
	end

endmodule

`default_nettype wire

// ==== logic/rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module rv_core
	import rv_core_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [`XLEN-1:0] inst,    // Word at pc_out, supplied combinationally
	output logic [`XLEN-1:0] alu_out,
	output logic [`PC_W-1:0] pc_out
);

	logic [4:0]       rs1_addr;
	logic [4:0]       rs2_addr;
	logic [4:0]       rd_addr;
	logic [`XLEN-1:0] imm;
	alu_op_e          alu_op;
	logic             alu_src;
	logic             reg_write;
	logic             mem_write;
	logic             is_branch;
	logic             branch_ne;
	wb_sel_e          wb_sel;
	logic [`XLEN-1:0] rs1_data;
	logic [`XLEN-1:0] rs2_data; // Also the store data
	logic [`XLEN-1:0] wb_data;
	logic             take_branch;
	logic [`PC_W-1:0] branch_target;

	rv_decode decode_i (
		.inst      (inst),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rd_addr   (rd_addr),
		.imm       (imm),
		.alu_op    (alu_op),
		.alu_src   (alu_src),
		.reg_write (reg_write),
		.mem_write (mem_write),
		.is_branch (is_branch),
		.branch_ne (branch_ne),
		.wb_sel    (wb_sel)
	);

	rv_regfile regfile_i (
		.clk       (clk),
		.rst       (rst),
		.rs1_addr  (rs1_addr),
		.rs2_addr  (rs2_addr),
		.rd_addr   (rd_addr),
		.reg_write (reg_write),
		.wb_data   (wb_data),
		.rs1_data  (rs1_data),
		.rs2_data  (rs2_data)
	);

	rv_execute execute_i (
		.rs1_data      (rs1_data),
		.rs2_data      (rs2_data),
		.imm           (imm),
		.pc            (pc_out),
		.alu_op        (alu_op),
		.alu_src       (alu_src),
		.is_branch     (is_branch),
		.branch_ne     (branch_ne),
		.alu_result    (alu_out),
		.take_branch   (take_branch),
		.branch_target (branch_target)
	);

	rv_result result_i (
		.clk           (clk),
		.rst           (rst),
		.alu_result    (alu_out),
		.store_data    (rs2_data),
		.mem_write     (mem_write),
		.wb_sel        (wb_sel),
		.take_branch   (take_branch),
		.branch_target (branch_target),
		.wb_data       (wb_data),
		.pc            (pc_out)
	);

endmodule

`default_nettype wire

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD = 10 // In ns, 20 ns period
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(HALF_PERIOD) clk = ~clk;

endmodule

`default_nettype wire

// ==== bench/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_params.svh"

module tb_rv_core;

	localparam logic [6:0] OP_R  = 7'h33;
	localparam logic [6:0] OP_I  = 7'h13;
	localparam logic [6:0] OP_LD = 7'h03;
	localparam logic [6:0] OP_ST = 7'h23;
	localparam logic [6:0] OP_BR = 7'h63;
	localparam int ROM_WORDS = 512;

	logic             clk;
	logic             rst;
	logic [`XLEN-1:0] inst;
	logic [`XLEN-1:0] alu_out;
	logic [`PC_W-1:0] pc_out;

	logic [31:0] rom [ROM_WORDS];
	logic [8:0]  wr_idx;
	logic [31:0] rng;
	string       test_name;
	string       names [$];
	logic [63:0] ends [$]; // End address of each program

	logic [31:0] model_regs [32];
	logic [31:0] model_mem [`DMEM_WORDS];
	logic [63:0] model_pc;
	logic [63:0] exp_pc;
	logic [31:0] exp_alu;
	logic        alu_defined; // alu_out has no defined value for unsupported opcodes
	int          cycle_cnt = 0;

	tb_clock clock_i (.clk(clk));

	rv_core dut_i (
		.clk     (clk),
		.rst     (rst),
		.inst    (inst),
		.alu_out (alu_out),
		.pc_out  (pc_out)
	);

	assign inst = rom[pc_out[10:2]]; // ROM answers combinationally

	function automatic logic [31:0] next_rand();
		rng = rng ^ (rng << 13);
		rng = rng ^ (rng >> 17);
		rng = rng ^ (rng << 5);
		return rng;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, OP_R};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
			input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	// sw rs2, imm(rs1)
	function automatic logic [31:0] enc_s(input logic [4:0] rs2, input logic [4:0] rs1,
			input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_ST};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
			input logic [4:0] rs2, input logic [12:0] off);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BR};
	endfunction

	function automatic logic [31:0] imm_of(input logic [31:0] w);
		case (w[6:0])
			OP_ST:   return {{20{w[31]}}, w[31:25], w[11:7]};
			OP_BR:   return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
			default: return {{20{w[31]}}, w[31:20]};
		endcase
	endfunction

	function automatic logic is_defined(input logic [31:0] w);
		return w[6:0] inside {OP_R, OP_I, OP_LD, OP_ST, OP_BR};
	endfunction

	// Expected ALU value of an instruction against the model registers
	function automatic logic [31:0] ref_alu(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		a = model_regs[w[19:15]];
		b = (w[6:0] == OP_R || w[6:0] == OP_BR) ? model_regs[w[24:20]] : imm_of(w);
		if (w[6:0] == OP_BR) begin
			res = a - b; // Branch compare
		end else if (w[6:0] != OP_R && w[6:0] != OP_I) begin
			res = a + b; // Load and store address
		end else begin
			case (w[14:12])
				3'd0:    res = (w[6:0] == OP_R && w[30]) ? a - b : a + b;
				3'd1:    res = a << b[4:0];
				3'd2:    res = {31'd0, $signed(a) < $signed(b)};
				3'd3:    res = {31'd0, a < b};
				3'd4:    res = a ^ b;
				3'd5:    res = w[30] ? $unsigned($signed(a) >>> b[4:0]) : (a >> b[4:0]);
				3'd6:    res = a | b;
				default: res = a & b;
			endcase
		end
		return res;
	endfunction

	task automatic step_model();
		logic [31:0] w;
		logic [31:0] res;
		logic [31:0] imm;
		logic [63:0] next_pc;
		w       = rom[model_pc[10:2]];
		res     = ref_alu(w);
		imm     = imm_of(w);
		next_pc = model_pc + 64'd4;
		case (w[6:0])
			OP_R, OP_I: model_regs[w[11:7]] = res;
			OP_LD:      model_regs[w[11:7]] = model_mem[res[8:2]];
			OP_ST:      model_mem[res[8:2]] = model_regs[w[24:20]];
			OP_BR: begin
				if ((res == 32'd0) != w[12]) begin // funct3 bit 0 marks bne
					next_pc = model_pc + {{32{imm[31]}}, imm};
				end
			end
			default: ;
		endcase
		model_regs[0] = '0;
		model_pc      = next_pc;
	endtask

	always @(posedge clk) begin
		if (rst) begin
			model_pc = `RESET_PC;
			for (int i = 0; i < 32; i++) begin
				model_regs[i] = '0;
			end
			for (int i = 0; i < `DMEM_WORDS; i++) begin
				model_mem[i] = '0;
			end
		end else begin
			step_model();
		end
		exp_pc      <= model_pc;
		exp_alu     <= ref_alu(rom[model_pc[10:2]]);
		alu_defined <= is_defined(rom[model_pc[10:2]]);
		cycle_cnt   <= cycle_cnt + 1;
	end

	task automatic report_mismatch(input string what, input logic [63:0] expv,
			input logic [63:0] actv);
		$display("Error %s: %s expected %h actual %h", test_name, what, expv, actv);
		$display("TEST FAIL");
		$fatal(1, "Output mismatch");
	endtask

	reset_pc_check: assert property (@(posedge clk)
			(cycle_cnt != 0 && $past(rst)) |-> (pc_out == `RESET_PC))
		else report_mismatch("pc_out after reset", `RESET_PC, $sampled(pc_out));

	pc_check: assert property (@(posedge clk) (cycle_cnt != 0) |-> (pc_out == exp_pc))
		else report_mismatch("pc_out", $sampled(exp_pc), $sampled(pc_out));

	alu_check: assert property (@(posedge clk)
			(cycle_cnt != 0 && !rst && alu_defined) |-> (alu_out == exp_alu))
		else report_mismatch("alu_out", {32'd0, $sampled(exp_alu)},
			{32'd0, $sampled(alu_out)});

	task automatic emit(input logic [31:0] w);
		rom[wr_idx] = w;
		wr_idx      = wr_idx + 9'd1;
	endtask

	task automatic close_test(input string name);
		names.push_back(name);
		ends.push_back({53'd0, wr_idx, 2'b00});
	endtask

	// A byte at a time through addi and slli
	task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
		emit(enc_i(OP_I, 3'd0, rd, 5'd0, {4'd0, v[31:24]}));
		for (int s = 16; s >= 0; s -= 8) begin
			emit(enc_i(OP_I, 3'd1, rd, rd, 12'd8));
			emit(enc_i(OP_I, 3'd0, rd, rd, {4'd0, v[s+:8]}));
		end
	endtask

	task automatic build_arith();
		logic [31:0] rnd;
		logic [2:0]  f3;
		logic        alt;
		for (int r = 0; r < 3; r++) begin
			load_const(5'd1, next_rand());
			load_const(5'd2, next_rand());
			for (int f = 0; f < 8; f++) begin
				emit(enc_r(7'h00, f[2:0], 5'(3 + f), 5'd1, 5'd2));
			end
			emit(enc_r(7'h20, 3'd0, 5'd11, 5'd1, 5'd2)); // sub
			emit(enc_r(7'h20, 3'd5, 5'd12, 5'd1, 5'd2)); // sra
			for (int f = 0; f < 9; f++) begin
				rnd = next_rand();
				alt = (f == 8); // Last pass is srai
				f3  = alt ? 3'd5 : f[2:0];
				if (f3 == 3'd1 || f3 == 3'd5) begin
					rnd[11:5] = {1'b0, alt, 5'd0};
				end
				emit(enc_i(OP_I, f3, 5'(13 + f), 5'd1, rnd[11:0]));
			end
		end
		close_test("arith");
	endtask

	task automatic build_x0();
		emit(enc_i(OP_I, 3'd0, 5'd0, 5'd1, 12'h123));
		emit(enc_r(7'h00, 3'd0, 5'd0, 5'd1, 5'd2));
		emit(enc_r(7'h20, 3'd5, 5'd0, 5'd1, 5'd2));
		emit(enc_i(OP_LD, 3'd2, 5'd0, 5'd0, 12'd0));
		emit(enc_r(7'h00, 3'd0, 5'd22, 5'd0, 5'd1)); // Only x1 shows
		emit(enc_r(7'h00, 3'd0, 5'd23, 5'd2, 5'd0));
		close_test("x0");
	endtask

	task automatic build_mem();
		load_const(5'd7, next_rand());
		load_const(5'd8, next_rand());
		emit(enc_i(OP_I, 3'd0, 5'd9, 5'd0, 12'd64)); // Base address
		emit(enc_s(5'd7, 5'd9, 12'd0));
		emit(enc_i(OP_LD, 3'd2, 5'd10, 5'd9, 12'd0));
		emit(enc_r(7'h00, 3'd0, 5'd11, 5'd10, 5'd0));
		emit(enc_s(5'd8, 5'd9, 12'd4));
		emit(enc_i(OP_LD, 3'd2, 5'd12, 5'd9, 12'd4));
		emit(enc_r(7'h00, 3'd0, 5'd13, 5'd12, 5'd0));
		emit(enc_i(OP_LD, 3'd2, 5'd14, 5'd9, 12'd0));
		emit(enc_r(7'h00, 3'd0, 5'd15, 5'd14, 5'd0));
		emit(enc_s(5'd7, 5'd0, 12'd520)); // Wraps onto word 2
		emit(enc_i(OP_LD, 3'd2, 5'd16, 5'd0, 12'd8));
		emit(enc_r(7'h00, 3'd0, 5'd17, 5'd16, 5'd0));
		emit(enc_s(5'd8, 5'd9, 12'hffc));
		emit(enc_i(OP_LD, 3'd2, 5'd18, 5'd0, 12'd572)); // Same word as 60
		emit(enc_r(7'h00, 3'd0, 5'd19, 5'd18, 5'd0));
		close_test("mem");
	endtask

	task automatic build_branch();
		emit(enc_i(OP_I, 3'd0, 5'd20, 5'd0, 12'd5));
		emit(enc_i(OP_I, 3'd0, 5'd21, 5'd0, 12'd5));
		emit(enc_i(OP_I, 3'd0, 5'd22, 5'd0, 12'd7));
		emit(enc_i(OP_I, 3'd0, 5'd24, 5'd0, 12'd0));
		emit(enc_b(3'd0, 5'd20, 5'd21, 13'd8)); // beq taken
		emit(enc_i(OP_I, 3'd0, 5'd23, 5'd0, 12'd1));
		emit(enc_b(3'd1, 5'd20, 5'd21, 13'd8));
		emit(enc_b(3'd0, 5'd20, 5'd22, 13'd8));
		emit(enc_b(3'd1, 5'd20, 5'd22, 13'd8)); // bne taken
		emit(enc_i(OP_I, 3'd0, 5'd23, 5'd23, 12'd2));
		emit(enc_b(3'd0, 5'd0, 5'd0, 13'd8));
		emit(enc_b(3'd0, 5'd0, 5'd0, 13'd8));
		emit(enc_b(3'd0, 5'd0, 5'd0, 13'h1ffc)); // Back by one word
		emit(enc_i(OP_I, 3'd0, 5'd24, 5'd24, 12'd1));
		emit(enc_b(3'd1, 5'd24, 5'd22, 13'h1ffc)); // Loop until x24 is 7
		emit(enc_r(7'h00, 3'd0, 5'd25, 5'd23, 5'd0));
		close_test("branch");
	endtask

	task automatic build_unsupported();
		logic [31:0] rnd;
		rnd = next_rand();
		emit({rnd[31:12], 5'd26, 7'h0b});
		rnd = next_rand();
		emit({rnd[31:12], 5'd26, 7'h37}); // lui
		rnd = next_rand();
		emit({rnd[31:12], 5'd26, 7'h6f}); // jal
		emit({7'd0, 5'd8, 5'd9, 3'b010, 5'd0, 7'h27}); // fsw of x8 onto word 16
		emit(enc_r(7'h00, 3'd0, 5'd27, 5'd26, 5'd0));
		emit(enc_i(OP_LD, 3'd2, 5'd28, 5'd9, 12'd0));
		emit(enc_r(7'h00, 3'd0, 5'd29, 5'd28, 5'd0));
		close_test("unsupported");
	endtask

	initial begin
		logic reached;
		logic timed_out;
		rst       = 1'b1;
		rng       = 32'd49373;
		wr_idx    = '0;
		test_name = "reset";
		timed_out = 1'b0;
		for (int i = 0; i < ROM_WORDS; i++) begin
			rom[i] = {i[24:0], 7'h7f}; // Unsupported opcode tagged with its index
		end
		build_arith();
		build_x0();
		build_mem();
		build_branch();
		build_unsupported();
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		foreach (names[t]) begin
			if (!timed_out) begin
				test_name = names[t];
				reached   = 1'b0;
				for (int c = 0; c < 200 && !reached; c++) begin
					@(negedge clk);
					reached = (pc_out == ends[t]);
				end
				if (!reached) begin
					$display("Timeout in %s: pc_out never reached %h in 200 cycles",
						test_name, ends[t]);
					timed_out = 1'b1;
				end
			end
		end
		if (timed_out) begin
			$display("TEST FAIL");
			$fatal(1, "Program did not finish");
		end else begin
			$display("TEST PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+logic
logic/rv_core_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_result.sv
logic/rv_core.sv
bench/tb_clock.sv
bench/tb_rv_core.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --assert --timing
TOP      = tb_rv_core
FILELIST = compile.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
